//--- common/rv_fetch_pkg.sv
package rv_fetch_pkg;

    //////////////////////////////////////////////////
    // address and data widths

    // default byte address width of the fetch path.
    localparam int IADDR_BITS = 16;

    // one instruction halfword, the unit the fetch buffer stores.
    typedef logic [15:0] parcel_t;

    typedef logic [31:0] word_t;    // memory word or a full instruction.

    //////////////////////////////////////////////////
    // fetch controller

    // IDLE may request, WAIT has read data on the memory bus this cycle,
    // DROP follows a redirect that hit a pending read.
    typedef enum logic [1:0]
    {
        IDLE,
        WAIT,
        DROP
    } fetch_state_e;

endpackage

//--- source/inst_mem.sv
`timescale 1ns/1ps

module inst_mem
#(
    parameter int IADDR_BITS     = rv_fetch_pkg::IADDR_BITS,
    parameter int MEM_WORDS_BITS = 10
)
(
    input  logic                    i_clk,
    input  logic                    i_en,
    input  logic                    i_we,
    input  logic [IADDR_BITS-3:0]   i_addr,
    input  rv_fetch_pkg::word_t     i_wdata,
    output rv_fetch_pkg::word_t     o_rdata
);

    localparam int WORDS = 2 ** MEM_WORDS_BITS;

    rv_fetch_pkg::word_t        mem [WORDS];
    logic                       in_range;
    logic [MEM_WORDS_BITS-1:0]  index;

    // word addresses beyond the array read as zero and ignore writes.
    assign in_range = ((i_addr >> MEM_WORDS_BITS) == '0);
    assign index    = i_addr[MEM_WORDS_BITS-1:0];

    always_ff @(posedge i_clk)
    begin
        if (i_en)
        begin
            if (i_we)
            begin
                if (in_range)
                    mem[index] <= i_wdata;
                o_rdata <= i_wdata;     // write data shows on the read port.
            end
            else
            begin
                o_rdata <= in_range ? mem[index] : '0;
            end
        end
    end

endmodule

//--- source/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter
#(
    parameter int IADDR_BITS     = rv_fetch_pkg::IADDR_BITS,
    parameter int MEM_WORDS_BITS = 10
)
(
    input  logic                        i_clk,
    input  logic                        i_reset_n,

    input  logic                        i_dmem_req,
    input  logic                        i_dmem_we,
    input  logic [MEM_WORDS_BITS-1:0]   i_dmem_addr,
    input  rv_fetch_pkg::word_t         i_dmem_wdata,
    output rv_fetch_pkg::word_t         o_dmem_rdata,
    output logic                        o_dmem_ack,

    input  logic                        i_fetch_req,
    input  logic [IADDR_BITS-3:0]       i_fetch_addr,
    output logic                        o_fetch_gnt,

    output logic                        o_mem_en,
    output logic                        o_mem_we,
    output logic [IADDR_BITS-3:0]       o_mem_addr,
    output rv_fetch_pkg::word_t         o_mem_wdata,
    input  rv_fetch_pkg::word_t         i_mem_rdata
);

    logic dmem_owner;   // data port owned the memory last cycle.

    //////////////////////////////////////////////////
    // request side

    // the data port always wins, fetch only gets idle cycles.
    assign o_fetch_gnt = i_fetch_req & !i_dmem_req;

    assign o_mem_en    = i_dmem_req | i_fetch_req;
    assign o_mem_we    = i_dmem_req & i_dmem_we;
    assign o_mem_addr  = i_dmem_req ? (IADDR_BITS-2)'(i_dmem_addr) : i_fetch_addr;
    assign o_mem_wdata = i_dmem_wdata;

    //////////////////////////////////////////////////
    // response side

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            dmem_owner <= 1'b0;
        else
            dmem_owner <= i_dmem_req;
    end

    assign o_dmem_ack   = dmem_owner;
    assign o_dmem_rdata = dmem_owner ? i_mem_rdata : '0;   // fetch data stays private.

endmodule

//--- fetch/fetch_ctrl.sv
`timescale 1ns/1ps

module fetch_ctrl
#(
    parameter int          IADDR_BITS = rv_fetch_pkg::IADDR_BITS,
    parameter int unsigned RESET_PC   = 0
)
(
    input  logic                        i_clk,
    input  logic                        i_reset_n,

    input  logic                        i_redirect,
    input  logic [IADDR_BITS-1:1]       i_redirect_pc,

    output logic                        o_fetch_req,
    output logic [IADDR_BITS-3:0]       o_fetch_addr,
    input  logic                        i_fetch_gnt,
    input  rv_fetch_pkg::word_t         i_mem_rdata,

    input  logic                        i_buf_full,
    output logic                        o_push_single,
    output logic                        o_push_double,
    output rv_fetch_pkg::parcel_t       o_data_lo,
    output rv_fetch_pkg::parcel_t       o_data_hi
);

    rv_fetch_pkg::fetch_state_e state;
    rv_fetch_pkg::fetch_state_e state_next;

    logic [IADDR_BITS-1:1]      fetch_pc;
    logic                       odd_half;
    logic                       resp_valid;

    // the low pc bit picks the halfword inside the word.
    assign odd_half     = fetch_pc[1];
    assign o_fetch_addr = fetch_pc[IADDR_BITS-1:2];

    //////////////////////////////////////////////////
    // state machine

    always_comb
    begin
        state_next = state;
        case (state)
            rv_fetch_pkg::IDLE:
            begin
                if (i_fetch_gnt)
                    state_next = rv_fetch_pkg::WAIT;
            end
            rv_fetch_pkg::WAIT:
            begin
                // a redirect here makes the word on the bus stale.
                if (i_redirect)
                    state_next = rv_fetch_pkg::DROP;
                else
                    state_next = rv_fetch_pkg::IDLE;
            end
            rv_fetch_pkg::DROP:
            begin
                state_next = rv_fetch_pkg::IDLE;   // one quiet cycle after the flush.
            end
            default:
            begin
                state_next = rv_fetch_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            state <= rv_fetch_pkg::IDLE;
        else
            state <= state_next;
    end

    //////////////////////////////////////////////////
    // request and push

    assign o_fetch_req = (state == rv_fetch_pkg::IDLE) & !i_buf_full & !i_redirect;

    assign resp_valid    = (state == rv_fetch_pkg::WAIT) & !i_redirect;
    assign o_push_single = resp_valid & odd_half;    // only the upper parcel is wanted.
    assign o_push_double = resp_valid & !odd_half;
    assign o_data_lo     = i_mem_rdata[15:0];
    assign o_data_hi     = i_mem_rdata[31:16];

    // the fetch pc moves by the number of parcels pushed.
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            fetch_pc <= (IADDR_BITS-1)'(RESET_PC);
        else if (i_redirect)
            fetch_pc <= i_redirect_pc;
        else if (o_push_single)
            fetch_pc <= fetch_pc + 1'b1;
        else if (o_push_double)
            fetch_pc <= fetch_pc + 2'd2;
    end

endmodule

//--- fetch/rv_fetch_buf.sv
`timescale 1ns/1ps

module rv_fetch_buf
#(
    parameter int          IADDR_BITS = rv_fetch_pkg::IADDR_BITS,
    parameter int          DEPTH_BITS = 2,
    parameter int unsigned RESET_PC   = 0
)
(
    input  logic                        i_clk,
    input  logic                        i_reset_n,

    input  logic                        i_redirect,
    input  logic [IADDR_BITS-1:1]       i_redirect_pc,

    input  rv_fetch_pkg::parcel_t       i_data_lo,
    input  rv_fetch_pkg::parcel_t       i_data_hi,
    input  logic                        i_push_single,
    input  logic                        i_push_double,

    input  logic                        i_pop,
    output rv_fetch_pkg::parcel_t       o_data_lo,
    output rv_fetch_pkg::parcel_t       o_data_hi,
    output logic [IADDR_BITS-1:1]       o_pc,

    output logic                        o_empty,
    output logic                        o_full
);

    localparam int QSIZE  = 2 ** DEPTH_BITS;
    localparam int HEAD_W = DEPTH_BITS + 1;

    rv_fetch_pkg::parcel_t  data [QSIZE];

    logic [HEAD_W-1:0]      head;           // number of parcels held.
    logic [HEAD_W-1:0]      head_next_pop;
    logic [HEAD_W-1:0]      head_next;
    logic [HEAD_W-1:0]      pop_count;
    logic [HEAD_W-1:0]      push_count;

    logic                   is_comp;
    logic                   pop_single;
    logic                   pop_double;
    logic                   push_single;
    logic                   push_double;

    logic [IADDR_BITS-1:1]  pc;
    logic [IADDR_BITS-1:1]  pc_incr;

    //////////////////////////////////////////////////
    // queue occupancy

    // anything but 2'b11 in the low bits marks a compressed instruction.
    assign is_comp = (data[0][1:0] != 2'b11);

    assign pop_single = i_pop & is_comp;
    assign pop_double = i_pop & !is_comp;

    // pushes landing together with a redirect belong to the old stream.
    assign push_single = i_push_single & !i_redirect;
    assign push_double = i_push_double & !i_redirect;

    assign pop_count  = HEAD_W'({pop_double, pop_single});
    assign push_count = HEAD_W'({push_double, push_single});

    // pop first, then append behind what is left.
    assign head_next_pop = head - pop_count;
    assign head_next     = head_next_pop + push_count;

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n || i_redirect)
            head <= '0;
        else
            head <= head_next;
    end

    // a full instruction needs both of its parcels before it is shown.
    assign o_empty = (head == '0) | ((head == HEAD_W'(1)) & !is_comp);
    assign o_full  = (head > HEAD_W'(QSIZE - 2));  // fewer than two free slots.

    //////////////////////////////////////////////////
    // parcel slots

    for (genvar i = 0; i < QSIZE; i++)
    begin : g_slot
        logic                   update_lo;
        logic                   update_hi;
        logic                   write_en;
        rv_fetch_pkg::parcel_t  shift_1;
        rv_fetch_pkg::parcel_t  shift_2;
        rv_fetch_pkg::parcel_t  next;

        assign update_hi = (push_single & (head_next_pop == HEAD_W'(i))) |
                           (push_double & (i > 0) & (head_next_pop == HEAD_W'(i - 1)));
        assign update_lo = push_double & (head_next_pop == HEAD_W'(i));

        if (i + 1 < QSIZE)
        begin : g_shift_1
            assign shift_1 = data[i + 1];
        end
        else
        begin : g_zero_1
            assign shift_1 = '0;
        end

        if (i + 2 < QSIZE)
        begin : g_shift_2
            assign shift_2 = data[i + 2];
        end
        else
        begin : g_zero_2
            assign shift_2 = '0;
        end

        assign next = update_hi  ? i_data_hi :
                      update_lo  ? i_data_lo :
                      pop_single ? shift_1 :
                                   shift_2;

        assign write_en = update_hi | update_lo | pop_single | pop_double;

        always_ff @(posedge i_clk)
        begin
            if (write_en)
                data[i] <= next;
        end
    end

    //////////////////////////////////////////////////
    // program counter

    assign pc_incr = is_comp ? (IADDR_BITS-1)'(1) : (IADDR_BITS-1)'(2);

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            pc <= (IADDR_BITS-1)'(RESET_PC);
        else if (i_redirect)
            pc <= i_redirect_pc;
        else if (i_pop)
            pc <= pc + pc_incr;
    end

    assign o_data_lo = data[0];
    assign o_data_hi = data[1];
    assign o_pc      = pc;

endmodule

//--- source/fetch_top.sv
`timescale 1ns/1ps

module fetch_top
#(
    parameter int          IADDR_BITS     = rv_fetch_pkg::IADDR_BITS,
    parameter int          DEPTH_BITS     = 2,
    parameter int          MEM_WORDS_BITS = 10,
    parameter int unsigned RESET_PC       = 0
)
(
    input  logic                        i_clk,
    input  logic                        i_reset_n,

    input  logic                        i_redirect,
    input  logic [IADDR_BITS-1:1]       i_redirect_pc,

    input  logic                        i_dmem_req,
    input  logic                        i_dmem_we,
    input  logic [MEM_WORDS_BITS-1:0]   i_dmem_addr,
    input  rv_fetch_pkg::word_t         i_dmem_wdata,
    output rv_fetch_pkg::word_t         o_dmem_rdata,
    output logic                        o_dmem_ack,

    output rv_fetch_pkg::word_t         o_instr,
    output logic [IADDR_BITS-1:1]       o_instr_pc,
    output logic                        o_instr_valid,
    input  logic                        i_instr_ready
);

    logic                   fetch_req;
    logic                   fetch_gnt;
    logic [IADDR_BITS-3:0]  fetch_addr;

    logic                   mem_en;
    logic                   mem_we;
    logic [IADDR_BITS-3:0]  mem_addr;
    rv_fetch_pkg::word_t    mem_wdata;
    rv_fetch_pkg::word_t    mem_rdata;

    logic                   push_single;
    logic                   push_double;
    rv_fetch_pkg::parcel_t  data_lo;
    rv_fetch_pkg::parcel_t  data_hi;
    logic                   buf_full;
    logic                   buf_empty;
    logic                   buf_pop;
    rv_fetch_pkg::parcel_t  instr_lo;
    rv_fetch_pkg::parcel_t  instr_hi;

    //////////////////////////////////////////////////
    // memory and its arbiter

    inst_mem #(
        .IADDR_BITS     (IADDR_BITS),
        .MEM_WORDS_BITS (MEM_WORDS_BITS)
    ) inst_mem_i (
        .i_clk          (i_clk),
        .i_en           (mem_en),
        .i_we           (mem_we),
        .i_addr         (mem_addr),
        .i_wdata        (mem_wdata),
        .o_rdata        (mem_rdata)
    );

    mem_arbiter #(
        .IADDR_BITS     (IADDR_BITS),
        .MEM_WORDS_BITS (MEM_WORDS_BITS)
    ) mem_arbiter_i (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_dmem_req     (i_dmem_req),
        .i_dmem_we      (i_dmem_we),
        .i_dmem_addr    (i_dmem_addr),
        .i_dmem_wdata   (i_dmem_wdata),
        .o_dmem_rdata   (o_dmem_rdata),
        .o_dmem_ack     (o_dmem_ack),
        .i_fetch_req    (fetch_req),
        .i_fetch_addr   (fetch_addr),
        .o_fetch_gnt    (fetch_gnt),
        .o_mem_en       (mem_en),
        .o_mem_we       (mem_we),
        .o_mem_addr     (mem_addr),
        .o_mem_wdata    (mem_wdata),
        .i_mem_rdata    (mem_rdata)
    );

    //////////////////////////////////////////////////
    // fetch path

    fetch_ctrl #(
        .IADDR_BITS     (IADDR_BITS),
        .RESET_PC       (RESET_PC)
    ) fetch_ctrl_i (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_redirect     (i_redirect),
        .i_redirect_pc  (i_redirect_pc),
        .o_fetch_req    (fetch_req),
        .o_fetch_addr   (fetch_addr),
        .i_fetch_gnt    (fetch_gnt),
        .i_mem_rdata    (mem_rdata),
        .i_buf_full     (buf_full),
        .o_push_single  (push_single),
        .o_push_double  (push_double),
        .o_data_lo      (data_lo),
        .o_data_hi      (data_hi)
    );

    rv_fetch_buf #(
        .IADDR_BITS     (IADDR_BITS),
        .DEPTH_BITS     (DEPTH_BITS),
        .RESET_PC       (RESET_PC)
    ) rv_fetch_buf_i (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_redirect     (i_redirect),
        .i_redirect_pc  (i_redirect_pc),
        .i_data_lo      (data_lo),
        .i_data_hi      (data_hi),
        .i_push_single  (push_single),
        .i_push_double  (push_double),
        .i_pop          (buf_pop),
        .o_data_lo      (instr_lo),
        .o_data_hi      (instr_hi),
        .o_pc           (o_instr_pc),
        .o_empty        (buf_empty),
        .o_full         (buf_full)
    );

    // an instruction leaves only when it is shown and taken.
    assign buf_pop       = i_instr_ready & !buf_empty;
    assign o_instr_valid = !buf_empty;
    assign o_instr       = {instr_hi, instr_lo};

endmodule

//--- verification/tb_fetch_top.sv
`timescale 1ns/1ps

module tb_fetch_top;

    localparam int IADDR_BITS     = 16;
    localparam int DEPTH_BITS     = 2;
    localparam int MEM_WORDS_BITS = 10;
    localparam int PARCELS        = 256;        // program size in halfwords.
    localparam int PROG_WORDS     = PARCELS / 2;
    localparam int SPARE_WORD     = 1000;       // outside the program.
    localparam int PHASE_INSTR    = 60;
    localparam int TOTAL_INSTR    = 3 * PHASE_INSTR;
    localparam int SEED           = 32'h4a69c631;

    logic                           i_clk;
    logic                           i_reset_n;
    logic                           i_redirect;
    logic [IADDR_BITS-1:1]          i_redirect_pc;
    logic                           i_dmem_req;
    logic                           i_dmem_we;
    logic [MEM_WORDS_BITS-1:0]      i_dmem_addr;
    rv_fetch_pkg::word_t            i_dmem_wdata;
    rv_fetch_pkg::word_t            o_dmem_rdata;
    logic                           o_dmem_ack;
    rv_fetch_pkg::word_t            o_instr;
    logic [IADDR_BITS-1:1]          o_instr_pc;
    logic                           o_instr_valid;
    logic                           i_instr_ready;

    rv_fetch_pkg::parcel_t          prog [PARCELS];
    rv_fetch_pkg::word_t            shadow [2**MEM_WORDS_BITS];
    int                             model_pc;
    int                             accepted;
    int                             total_instr;
    int                             checks;
    int                             errors;
    int                             reads;
    bit                             checking;
    bit                             stream_done;
    logic                           prev_req;
    logic                           prev_we;
    logic [MEM_WORDS_BITS-1:0]      prev_addr;

    fetch_top #(
        .IADDR_BITS     (IADDR_BITS),
        .DEPTH_BITS     (DEPTH_BITS),
        .MEM_WORDS_BITS (MEM_WORDS_BITS),
        .RESET_PC       (0)
    ) fetch_top_i (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_redirect     (i_redirect),
        .i_redirect_pc  (i_redirect_pc),
        .i_dmem_req     (i_dmem_req),
        .i_dmem_we      (i_dmem_we),
        .i_dmem_addr    (i_dmem_addr),
        .i_dmem_wdata   (i_dmem_wdata),
        .o_dmem_rdata   (o_dmem_rdata),
        .o_dmem_ack     (o_dmem_ack),
        .o_instr        (o_instr),
        .o_instr_pc     (o_instr_pc),
        .o_instr_valid  (o_instr_valid),
        .i_instr_ready  (i_instr_ready)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    //////////////////////////////////////////////////
    // checkers

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors = errors + 1;
        $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
    endtask

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks = checks + 1;
        assert (expected === actual) else report_mismatch(name, expected, actual);
    endtask

    // every accepted instruction is compared with the parcel model.
    always @(negedge i_clk)
    begin
        if (checking && o_instr_valid && i_instr_ready)
        begin
            check_equal("o_instr_pc", 32'(model_pc), 32'(o_instr_pc));
            check_equal("o_instr[15:0]", 32'(prog[model_pc]), 32'(o_instr[15:0]));
            if (prog[model_pc][1:0] == 2'b11)
            begin
                check_equal("o_instr[31:16]", 32'(prog[model_pc + 1]), 32'(o_instr[31:16]));
                model_pc = model_pc + 2;
            end
            else
                model_pc = model_pc + 1;   // compressed.
            accepted    = accepted + 1;
            total_instr = total_instr + 1;
        end
    end

    // the data port acks exactly one cycle after each request.
    always @(negedge i_clk)
    begin
        if (i_reset_n)
        begin
            check_equal("o_dmem_ack", 32'(prev_req), 32'(o_dmem_ack));
            if (prev_req && !prev_we)
            begin
                check_equal("o_dmem_rdata", shadow[prev_addr], o_dmem_rdata);
                reads = reads + 1;
            end
        end
        prev_req  = i_dmem_req;
        prev_we   = i_dmem_we;
        prev_addr = i_dmem_addr;
    end

    //////////////////////////////////////////////////
    // stimulus

    // random mix of compressed and full instructions, full ones may span two words.
    task automatic build_program();
        int idx;
        idx = 0;
        while (idx < PARCELS)
        begin
            prog[idx] = rv_fetch_pkg::parcel_t'($urandom);
            if (idx < PARCELS - 1 && $urandom_range(0, 1) == 1)
            begin
                prog[idx][1:0] = 2'b11;
                prog[idx + 1]  = rv_fetch_pkg::parcel_t'($urandom);
                idx = idx + 2;
            end
            else
            begin
                prog[idx][1:0] = 2'($urandom_range(0, 2));
                idx = idx + 1;
            end
        end
    endtask

    task automatic write_word(input int addr, input rv_fetch_pkg::word_t data);
        i_dmem_req   <= 1'b1;
        i_dmem_we    <= 1'b1;
        i_dmem_addr  <= MEM_WORDS_BITS'(addr);
        i_dmem_wdata <= data;
        shadow[addr] = data;
        @(posedge i_clk);
    endtask

    task automatic read_word(input int addr);
        i_dmem_req  <= 1'b1;
        i_dmem_we   <= 1'b0;
        i_dmem_addr <= MEM_WORDS_BITS'(addr);
        @(posedge i_clk);
    endtask

    task automatic release_port();
        i_dmem_req <= 1'b0;
        i_dmem_we  <= 1'b0;
    endtask

    task automatic load_program();
        for (int w = 0; w < PROG_WORDS; w++)
            write_word(w, {prog[2 * w + 1], prog[2 * w]});
    endtask

    // the model restarts at the target once the flush is done.
    task automatic redirect_to(input int target);
        i_redirect    <= 1'b1;
        i_redirect_pc <= (IADDR_BITS-1)'(target);
        checking = 1'b0;
        @(posedge i_clk);
        i_redirect <= 1'b0;
        model_pc = target;
        accepted = 0;
        checking = 1'b1;
    endtask

    task automatic run_stream(input bit random_ready);
        while (accepted < PHASE_INSTR)
        begin
            i_instr_ready <= random_ready ? 1'($urandom_range(0, 1)) : 1'b1;
            @(posedge i_clk);
        end
        i_instr_ready <= 1'b0;
    endtask

    task automatic wait_fetch_grant();
        do
            @(negedge i_clk);
        while (!fetch_top_i.fetch_gnt);
        @(posedge i_clk);
    endtask

    task automatic drive_data_reads();
        while (!stream_done)
        begin
            i_dmem_req  <= ($urandom_range(0, 2) == 0);
            i_dmem_we   <= 1'b0;
            i_dmem_addr <= MEM_WORDS_BITS'($urandom_range(0, PROG_WORDS - 1));
            @(posedge i_clk);
        end
        release_port();
    endtask

    initial
    begin
        void'($urandom(SEED));
        i_reset_n     = 1'b0;
        i_redirect    = 1'b0;
        i_redirect_pc = '0;
        i_dmem_req    = 1'b0;
        i_dmem_we     = 1'b0;
        i_dmem_addr   = '0;
        i_dmem_wdata  = '0;
        i_instr_ready = 1'b0;
        build_program();
        repeat (2) @(posedge i_clk);
        i_reset_n <= 1'b1;
        @(negedge i_clk);
        check_equal("o_instr_valid", 32'(0), 32'(o_instr_valid));
        check_equal("o_dmem_ack", 32'(0), 32'(o_dmem_ack));
        @(posedge i_clk);

        load_program();
        for (int w = 0; w < PROG_WORDS; w++)
            read_word(w);
        write_word(SPARE_WORD, $urandom);
        write_word(SPARE_WORD, $urandom);   // the read must see this one.
        read_word(SPARE_WORD);
        release_port();

        redirect_to(0);
        run_stream(1'b0);

        // the old stream keeps flowing until a read is in flight.
        i_instr_ready <= 1'b1;
        wait_fetch_grant();
        redirect_to(2 * $urandom_range(4, 20) + 1);
        run_stream(1'b0);

        redirect_to(2 * $urandom_range(0, 30));
        fork
            begin
                run_stream(1'b1);
                stream_done = 1'b1;
            end
            drive_data_reads();
        join
        repeat (4) @(posedge i_clk);

        $display("checks %0d errors %0d instructions %0d data reads %0d",
                 checks, errors, total_instr, reads);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    initial
    begin
        repeat (TOTAL_INSTR * 40) @(posedge i_clk);
        $display("timeout after %0d cycles, the instruction stream stalled",
                 TOTAL_INSTR * 40);
        $display("Regression failed");
        $finish;
    end

endmodule

//--- sim.f
common/rv_fetch_pkg.sv
source/inst_mem.sv
source/mem_arbiter.sv
fetch/fetch_ctrl.sv
fetch/rv_fetch_buf.sv
source/fetch_top.sv
verification/tb_fetch_top.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass message in the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_fetch_top \
    -f sim.f -o tb_fetch_top > build.log 2>&1 \
    && ./obj_dir/tb_fetch_top > sim.log 2>&1 \
    || { echo "build or simulation did not complete"; exit 1; }

grep -qx "Regression passed" sim.log \
    && { echo "PASS"; exit 0; } \
    || { echo "FAIL, see sim.log"; exit 1; }
